// File: verilog/mem_rd_config.svh
// read-return build constants for data width and DQS watchdog limits
`ifndef MEM_RD_CONFIG_SVH
`define MEM_RD_CONFIG_SVH

// ------------------------------
// data path
// ------------------------------
// read data word width, 32, 64 or 128
`define AHB_DATA_WIDTH 32

// ------------------------------
// dqs watchdog
// ------------------------------
// counter width follows the data width
`define DQS_CNT_WIDTH ((`AHB_DATA_WIDTH == 32) ? 10 : ((`AHB_DATA_WIDTH == 64) ? 11 : 12))
// idle cycles without a strobe toggle before timeout
// must fit in DQS_CNT_WIDTH
`define DQS_TIMEOUT_CYCLES 64

`endif

// File: verilog/mem_rd_pkg.sv
// shared types and response codes for the serial memory read-return path
`default_nettype none

`include "mem_rd_config.svh"

package mem_rd_pkg;

   // ------------------------------
   // data and burst widths
   // ------------------------------
   // one received / returned data word
   typedef logic [`AHB_DATA_WIDTH-1:0] data_word_t;
   // axi burst length minus one
   typedef logic [7:0] axi_len_t;
   // axi read response
   typedef logic [1:0] axi_resp_t;

   // response codes in use
   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // dqs idle cycle count
   typedef logic [`DQS_CNT_WIDTH-1:0] dqs_cnt_t;

   // ------------------------------
   // read sequencer states
   // ------------------------------
   typedef enum logic [1:0]
   {
      IDLE           = 2'd0,
      RD_PROGRS      = 2'd1,
      CONT_RD_PROGRS = 2'd2
   } rd_state_e;

endpackage

`default_nettype wire

// File: verilog/rd_xfer_if.sv
// burst start and completion link between read sequencer and read-data controller
`timescale 1ns/1ps
`default_nettype none

interface rd_xfer_if;
   import mem_rd_pkg::*;

   // pulse, one per burst
   logic     rd_start;
   // beats minus one, valid with rd_start
   axi_len_t rd_len;
   // burst returns error beats only
   logic     rd_err;
   // pulse when the last beat is taken
   logic     burst_done;

   // sequencer side
   modport seq
   (
      output rd_start,
      output rd_len,
      output rd_err,
      input  burst_done
   );

   // data controller side
   modport data
   (
      input  rd_start,
      input  rd_len,
      input  rd_err,
      output burst_done
   );

endinterface

`default_nettype wire

// File: verilog/read_sequencer.sv
// read sequencer FSM that starts AXI read bursts and chains continuous reads
`timescale 1ns/1ps
`default_nettype none

module read_sequencer
(
   input  logic                mem_clk,
   input  logic                reset_n,

   // transfer request from the AXI slave controller
   input  logic                xfer_valid,
   input  logic                xfer_wr_rd,
   input  logic                cont_rd_req,
   input  logic                xfer_error,
   input  mem_rd_pkg::axi_len_t xfer_len,

   // transmit engine and error sources
   input  logic                xmittr_ack,
   input  logic                illegal_instrn_err,
   input  logic                dqs_timeout,

   output logic                rd_busy,
   output logic                rd_done,
   output logic                cont_rd_ack,

   rd_xfer_if.seq              xfer
);
   import mem_rd_pkg::*;

   rd_state_e state;
   rd_state_e state_nxt;

   logic rd_done_nxt;
   // error flag of the fresh read
   logic err_xfer;
   logic err_xfer_nxt;
   // latched dqs timeout
   logic dqs_to_reg;
   logic dqs_to_nxt;
   // latched illegal instruction edge
   logic ill_d1;
   logic ill_redge;
   logic ill_redge_reg;
   logic ill_redge_nxt;

   logic fresh_rd;
   logic cont_rd;
   logic chain;

   // ------------------------------
   // request decode
   // ------------------------------
   // new read accepted by the transmit engine
   assign fresh_rd  = xfer_valid & ~xfer_wr_rd & xmittr_ack;
   // controller asks to keep reading
   assign cont_rd   = xfer_valid & ~xfer_wr_rd & cont_rd_req;
   assign ill_redge = illegal_instrn_err & ~ill_d1;

   // ------------------------------
   // burst start toward data side
   // ------------------------------
   // fresh start only from idle
   // chained start together with the ack
   assign xfer.rd_start = ((state == IDLE) & fresh_rd) | chain;
   assign xfer.rd_len   = xfer_len;
   assign xfer.rd_err   = xfer_error;

   assign cont_rd_ack = chain;
   assign rd_busy     = (state != IDLE);

   // ------------------------------
   // next state
   // ------------------------------
   always_comb
   begin
      state_nxt     = state;
      rd_done_nxt   = 1'b0;
      err_xfer_nxt  = err_xfer;
      // a timeout in the ending cycle still counts
      dqs_to_nxt    = dqs_to_reg | dqs_timeout;
      ill_redge_nxt = ill_redge_reg;
      chain         = 1'b0;

      case (state)
         IDLE:
         begin
            if (fresh_rd)
            begin
               state_nxt    = RD_PROGRS;
               err_xfer_nxt = xfer_error;
            end
         end

         RD_PROGRS,
         CONT_RD_PROGRS:
         begin
            // illegal instruction only counts while busy
            ill_redge_nxt = ill_redge_reg | ill_redge;
            if (xfer.burst_done)
            begin
               // stop on timeout, illegal instr, error burst,
               // no pending request or an errored request
               if (dqs_to_nxt | ill_redge_nxt | err_xfer | ~cont_rd | xfer_error)
               begin
                  state_nxt     = IDLE;
                  rd_done_nxt   = 1'b1;
                  err_xfer_nxt  = 1'b0;
                  dqs_to_nxt    = 1'b0;
                  ill_redge_nxt = 1'b0;
               end
               else
               begin
                  // chain the next burst
                  state_nxt = CONT_RD_PROGRS;
                  chain     = 1'b1;
               end
            end
         end

         default:
         begin
            state_nxt = IDLE;
         end
      endcase
   end

   // ------------------------------
   // state registers
   // ------------------------------
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state         <= IDLE;
         rd_done       <= 1'b0;
         err_xfer      <= 1'b0;
         dqs_to_reg    <= 1'b0;
         ill_d1        <= 1'b0;
         ill_redge_reg <= 1'b0;
      end
      else
      begin
         state         <= state_nxt;
         rd_done       <= rd_done_nxt;
         err_xfer      <= err_xfer_nxt;
         dqs_to_reg    <= dqs_to_nxt;
         // edge detect runs in every state
         ill_d1        <= illegal_instrn_err;
         ill_redge_reg <= ill_redge_nxt;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dqs_watchdog.sv
// DQS watchdog that flags a read whose strobe stops toggling
`timescale 1ns/1ps
`default_nettype none

`include "mem_rd_config.svh"

module dqs_watchdog
(
   input  logic mem_clk,
   input  logic reset_n,
   // high while a read sequence runs
   input  logic rd_busy,
   // strobe toggled this cycle
   input  logic dqs_toggle,
   output logic dqs_timeout
);
   import mem_rd_pkg::*;

   // cycles since last toggle or start of read
   dqs_cnt_t cnt;
   // one pulse per read sequence
   logic     armed;
   logic     hit;

   // ------------------------------
   // timeout decode
   // ------------------------------
   assign hit         = armed & (cnt == dqs_cnt_t'(`DQS_TIMEOUT_CYCLES));
   assign dqs_timeout = hit;

   // ------------------------------
   // idle counter
   // ------------------------------
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         cnt   <= '0;
         armed <= 1'b1;
      end
      else if (!rd_busy)
      begin
         // re-arm between read sequences
         cnt   <= '0;
         armed <= 1'b1;
      end
      else
      begin
         if (dqs_toggle)
            cnt <= dqs_cnt_t'(1);
         // holds once disarmed
         else if (armed)
            cnt <= cnt + 1'b1;
         if (hit)
            armed <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/rdata_ctrl.sv
// read-data controller turning received words and error fills into AXI read beats
`timescale 1ns/1ps
`default_nettype none

module rdata_ctrl
(
   input  logic                   mem_clk,
   input  logic                   reset_n,

   // received words from the PHY
   input  mem_rd_pkg::data_word_t rx_data,
   input  logic                   rx_valid,
   output logic                   rx_ready,

   // AXI read beat
   output mem_rd_pkg::data_word_t rdata,
   output logic                   rdata_valid,
   output logic                   rlast,
   output mem_rd_pkg::axi_resp_t  rresp,
   input  logic                   rdata_ack,

   input  logic                   dqs_timeout,

   rd_xfer_if.data                xfer
);
   import mem_rd_pkg::*;

   // beats still to load for this burst
   logic     active;
   // generate SLVERR beats instead of taking words
   logic     fill;
   // beats left to load minus one
   axi_len_t rem;

   logic slot_free;
   logic take;
   logic fill_step;
   logic load;
   logic last_beat;

   // ------------------------------
   // load decode
   // ------------------------------
   // holding register empty or emptied this cycle
   assign slot_free = ~rdata_valid | rdata_ack;
   assign rx_ready  = active & ~fill & slot_free;
   assign take      = rx_ready & rx_valid;
   assign fill_step = active & fill & slot_free;
   assign load      = take | fill_step;
   assign last_beat = (rem == '0);

   // last beat of the burst accepted
   assign xfer.burst_done = rdata_valid & rdata_ack & rlast;

   // ------------------------------
   // burst control
   // ------------------------------
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         active      <= 1'b0;
         fill        <= 1'b0;
         rem         <= '0;
         rdata_valid <= 1'b0;
      end
      else
      begin
         if (xfer.rd_start)
         begin
            // previous burst fully loaded by now
            active <= 1'b1;
            fill   <= xfer.rd_err;
            rem    <= xfer.rd_len;
         end
         else
         begin
            // timeout turns the rest of the burst into error beats
            if (dqs_timeout && active)
               fill <= 1'b1;
            if (load)
            begin
               if (last_beat)
                  active <= 1'b0;
               else
                  rem <= rem - 1'b1;
            end
         end

         if (load)
            rdata_valid <= 1'b1;
         else if (rdata_ack)
            rdata_valid <= 1'b0;
      end
   end

   // ------------------------------
   // beat holding register
   // ------------------------------
   always_ff @(posedge mem_clk)
   begin
      if (load)
      begin
         // zero data on error fill
         rdata <= take ? rx_data : '0;
         rresp <= take ? RESP_OKAY : RESP_SLVERR;
         rlast <= last_beat;
      end
   end

endmodule

`default_nettype wire

// File: verilog/mem_rd_top.sv
// read-return top connecting sequencer, DQS watchdog and read-data controller
`timescale 1ns/1ps
`default_nettype none

module mem_rd_top
(
   input  logic                   mem_clk,
   input  logic                   reset_n,

   // transfer request from the AXI slave controller
   input  logic                   xfer_valid,
   input  logic                   xfer_wr_rd,
   input  logic                   cont_rd_req,
   input  logic                   xfer_error,
   input  mem_rd_pkg::axi_len_t   xfer_len,

   // transmit engine and instruction check
   input  logic                   xmittr_ack,
   input  logic                   illegal_instrn_err,

   // PHY receive side
   input  logic                   dqs_toggle,
   input  mem_rd_pkg::data_word_t rx_data,
   input  logic                   rx_valid,
   output logic                   rx_ready,

   // AXI read data channel
   output mem_rd_pkg::data_word_t rdata,
   output logic                   rdata_valid,
   output logic                   rlast,
   output mem_rd_pkg::axi_resp_t  rresp,
   input  logic                   rdata_ack,

   // completion toward transmit engine and ack resolver
   output logic                   rd_done,
   output logic                   cont_rd_ack
);

   // ------------------------------
   // internal links
   // ------------------------------
   rd_xfer_if xfer_if ();

   logic rd_busy;
   logic dqs_timeout;

   read_sequencer u_read_sequencer
   (
      .mem_clk            (mem_clk),
      .reset_n            (reset_n),
      .xfer_valid         (xfer_valid),
      .xfer_wr_rd         (xfer_wr_rd),
      .cont_rd_req        (cont_rd_req),
      .xfer_error         (xfer_error),
      .xfer_len           (xfer_len),
      .xmittr_ack         (xmittr_ack),
      .illegal_instrn_err (illegal_instrn_err),
      .dqs_timeout        (dqs_timeout),
      .rd_busy            (rd_busy),
      .rd_done            (rd_done),
      .cont_rd_ack        (cont_rd_ack),
      .xfer               (xfer_if.seq)
   );

   // watches the strobe while a read runs
   dqs_watchdog u_dqs_watchdog
   (
      .mem_clk     (mem_clk),
      .reset_n     (reset_n),
      .rd_busy     (rd_busy),
      .dqs_toggle  (dqs_toggle),
      .dqs_timeout (dqs_timeout)
   );

   rdata_ctrl u_rdata_ctrl
   (
      .mem_clk     (mem_clk),
      .reset_n     (reset_n),
      .rx_data     (rx_data),
      .rx_valid    (rx_valid),
      .rx_ready    (rx_ready),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .rlast       (rlast),
      .rresp       (rresp),
      .rdata_ack   (rdata_ack),
      .dqs_timeout (dqs_timeout),
      .xfer        (xfer_if.data)
   );

endmodule

`default_nettype wire

// File: bench/mem_rd_chk.sv
// assertion checker bound into the read-return top for sequencer and AXI beat rules
`timescale 1ns/1ps
`default_nettype none

module mem_rd_chk
(
   input logic                   mem_clk,
   input logic                   reset_n,
   input logic                   rd_done,
   input logic                   cont_rd_ack,
   input logic                   rd_busy,
   input mem_rd_pkg::data_word_t rdata,
   input logic                   rdata_valid,
   input logic                   rlast,
   input mem_rd_pkg::axi_resp_t  rresp,
   input logic                   rdata_ack
);

   // failed assertion count
   int fail_cnt = 0;

   // ------------------------------
   // sequencer completion
   // ------------------------------
   // a sequence either ends or chains, never both
   done_ack_excl: assert property (@(posedge mem_clk) disable iff (!reset_n)
      !(rd_done && cont_rd_ack))
   else
   begin
      $error("rd_done and cont_rd_ack high in the same cycle");
      fail_cnt++;
   end

   // back in idle once done is reported
   idle_after_done: assert property (@(posedge mem_clk) disable iff (!reset_n)
      rd_done |=> !rd_busy)
   else
   begin
      $error("rd_busy still high in the cycle after rd_done");
      fail_cnt++;
   end

   // ------------------------------
   // AXI read channel
   // ------------------------------
   // held beat must not move until taken
   beat_stable: assert property (@(posedge mem_clk) disable iff (!reset_n)
      (rdata_valid && !rdata_ack) |=>
         (rdata_valid && $stable(rdata) && $stable(rresp) && $stable(rlast)))
   else
   begin
      $error("read beat changed while waiting for rdata_ack");
      fail_cnt++;
   end

endmodule

// busy level taken from the top's internal wire
bind mem_rd_top mem_rd_chk u_mem_rd_chk
(
   .mem_clk     (mem_clk),
   .reset_n     (reset_n),
   .rd_done     (rd_done),
   .cont_rd_ack (cont_rd_ack),
   .rd_busy     (rd_busy),
   .rdata       (rdata),
   .rdata_valid (rdata_valid),
   .rlast       (rlast),
   .rresp       (rresp),
   .rdata_ack   (rdata_ack)
);

`default_nettype wire

// File: bench/mem_rd_tb.sv
// table-driven testbench for the read-return path with PHY and AXI master models
`timescale 1ns/1ps
`default_nettype none

`include "mem_rd_config.svh"

module mem_rd_tb;
   import mem_rd_pkg::*;

   localparam int          CLK_HALF    = 5;
   localparam int          NUM_TESTS   = 14;
   localparam int          MAX_WORDS   = 64;
   localparam int          TAIL_CYCLES = 4;
   localparam int          WR_CYCLES   = 20;
   localparam logic [31:0] SEED        = 32'h2dd3e1b5;

   // ------------------------------
   // stimulus table row
   // ------------------------------
   typedef struct packed
   {
      logic       is_wr;
      axi_len_t   len;
      // bursts requested, fresh one included
      int         nchain;
      // bit 0 fresh read, bit i continuous request i
      logic [7:0] err_mask;
      // PHY stops before this beat, -1 never
      int         to_beat;
      // illegal level rises once this word index is reached, -1 never
      int         ill_word;
      // rdata_ack per cycle mod 8, zero means random
      logic [7:0] ack_pat;
      int         exp_bursts;
      int         exp_done;
   } test_row_t;

   logic       mem_clk;
   logic       reset_n;
   logic       xfer_valid;
   logic       xfer_wr_rd;
   logic       cont_rd_req;
   logic       xfer_error;
   axi_len_t   xfer_len;
   logic       xmittr_ack;
   logic       illegal_instrn_err;
   logic       dqs_toggle;
   data_word_t rx_data;
   logic       rx_valid;
   logic       rx_ready;
   data_word_t rdata;
   logic       rdata_valid;
   logic       rlast;
   axi_resp_t  rresp;
   logic       rdata_ack;
   logic       rd_done;
   logic       cont_rd_ack;

   test_row_t   rows [NUM_TESTS];
   string       names [NUM_TESTS];
   data_word_t  words [MAX_WORDS];
   data_word_t  exp_data [$];
   axi_resp_t   exp_resp [$];
   logic        exp_last [$];
   logic [31:0] rng;
   int          n_rows;
   int          errors;
   int          checks;
   int          asrt_seen;
   int          beat_cnt;
   int          done_cnt;
   int          ack_cnt;
   // bursts started in this sequence
   int          started;
   // next word the PHY offers
   int          ptr;
   int          nwords;
   int          cyc;
   logic        fresh_pending;
   logic        seq_open;
   logic        table_ready;

   mem_rd_top DUT
   (
      .mem_clk            (mem_clk),
      .reset_n            (reset_n),
      .xfer_valid         (xfer_valid),
      .xfer_wr_rd         (xfer_wr_rd),
      .cont_rd_req        (cont_rd_req),
      .xfer_error         (xfer_error),
      .xfer_len           (xfer_len),
      .xmittr_ack         (xmittr_ack),
      .illegal_instrn_err (illegal_instrn_err),
      .dqs_toggle         (dqs_toggle),
      .rx_data            (rx_data),
      .rx_valid           (rx_valid),
      .rx_ready           (rx_ready),
      .rdata              (rdata),
      .rdata_valid        (rdata_valid),
      .rlast              (rlast),
      .rresp              (rresp),
      .rdata_ack          (rdata_ack),
      .rd_done            (rd_done),
      .cont_rd_ack        (cont_rd_ack)
   );

   always #(CLK_HALF) mem_clk = ~mem_clk;

   // ------------------------------
   // random words
   // ------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic gen_word(output data_word_t w);
      int i;
      w = '0;
      // 32 bits per step, wide words take several
      for (i = 0; i < (`AHB_DATA_WIDTH + 31) / 32; i++)
      begin
         rng = xorshift32(rng);
         w = (w << 32) | data_word_t'(rng);
      end
   endtask

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic verify_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic match_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("Fail t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // ------------------------------
   // table and expected beats
   // ------------------------------
   task automatic add_row(input string name, input logic is_wr, input int len,
                          input int nchain, input logic [7:0] err_mask, input int to_beat,
                          input int ill_word, input logic [7:0] ack_pat,
                          input int exp_bursts, input int exp_done);
      rows[n_rows] = '{is_wr, axi_len_t'(len), nchain, err_mask, to_beat, ill_word,
                       ack_pat, exp_bursts, exp_done};
      names[n_rows] = name;
      n_rows++;
   endtask

   task automatic load_table();
      n_rows = 0;
      //      name                    wr len  n  err    to  ill  ack  bursts done
      add_row("single len 3",         0,  3, 1, 8'h00, -1, -1, 8'hff, 1, 1);
      add_row("single len 0",         0,  0, 1, 8'h00, -1, -1, 8'hff, 1, 1);
      add_row("chain of 3",           0,  3, 3, 8'h00, -1, -1, 8'hff, 3, 1);
      add_row("chain of 2 gapped",    0,  7, 2, 8'h00, -1, -1, 8'hb6, 2, 1);
      add_row("fresh read error",     0,  3, 2, 8'h01, -1, -1, 8'hff, 1, 1);
      add_row("cont request error",   0,  3, 3, 8'h04, -1, -1, 8'hff, 2, 1);
      add_row("timeout in burst",     0,  7, 1, 8'h00,  3, -1, 8'hff, 1, 1);
      add_row("timeout in chain",     0,  3, 3, 8'h00,  6, -1, 8'hff, 2, 1);
      add_row("timeout at boundary",  0,  3, 3, 8'h00,  4, -1, 8'hff, 2, 1);
      add_row("illegal in burst 0",   0,  3, 3, 8'h00, -1,  2, 8'hff, 1, 1);
      add_row("illegal in burst 1",   0,  3, 4, 8'h00, -1,  6, 8'hff, 2, 1);
      add_row("random gaps chain",    0, 15, 2, 8'h00, -1, -1, 8'h00, 2, 1);
      add_row("write ignored",        1,  3, 1, 8'h00, -1, -1, 8'hff, 0, 0);
      add_row("random gaps single",   0,  5, 1, 8'h00, -1, -1, 8'h00, 1, 1);
   endtask

   task automatic build_expected(input test_row_t r);
      int b;
      int j;
      int g;
      exp_data.delete();
      exp_resp.delete();
      exp_last.delete();
      for (b = 0; b < r.exp_bursts; b++)
      begin
         for (j = 0; j <= r.len; j++)
         begin
            g = b * (r.len + 1) + j;
            // errored fresh read or past the strobe stop
            if ((b == 0 && r.err_mask[0]) || (r.to_beat >= 0 && g >= r.to_beat))
            begin
               exp_data.push_back('0);
               exp_resp.push_back(RESP_SLVERR);
            end
            else
            begin
               exp_data.push_back(words[g]);
               exp_resp.push_back(RESP_OKAY);
            end
            exp_last.push_back(j == r.len);
         end
      end
   endtask

   // ------------------------------
   // one clock of all models
   // ------------------------------
   task automatic one_cycle(input test_row_t r);
      @(negedge mem_clk);
      // AXI slave controller request
      xfer_valid  = seq_open;
      xfer_wr_rd  = r.is_wr;
      xfer_len    = r.len;
      xmittr_ack  = fresh_pending;
      cont_rd_req = seq_open && !fresh_pending && (started < r.nchain);
      if (fresh_pending)
         xfer_error = r.err_mask[0];
      else
         xfer_error = (started < r.nchain) ? r.err_mask[started] : 1'b0;
      // PHY offers words in order, strobe with each
      rx_valid = seq_open && !r.is_wr && (ptr < nwords)
                 && (r.to_beat < 0 || ptr < r.to_beat);
      rx_data    = rx_valid ? words[ptr] : '0;
      dqs_toggle = rx_valid;
      illegal_instrn_err = seq_open && (r.ill_word >= 0) && (ptr >= r.ill_word);
      // AXI master ready
      if (r.ack_pat == 8'h00)
      begin
         rng = xorshift32(rng);
         rdata_ack = rng[7];
      end
      else
         rdata_ack = r.ack_pat[cyc % 8];

      // settled, just ahead of the rising edge
      #(CLK_HALF - 1);
      // held beat blocks the PHY
      if (rdata_valid && !rdata_ack)
         compare_bit("rx_ready", rx_ready, 1'b0);
      if (rx_valid && rx_ready)
         ptr++;
      if (rdata_valid && rdata_ack)
      begin
         beat_cnt++;
         if (exp_data.size() == 0)
         begin
            errors++;
            $display("t=%0t read beat returned when no beat was expected", $time);
         end
         else
         begin
            check_word("rdata", rdata, exp_data.pop_front());
            verify_resp("rresp", rresp, exp_resp.pop_front());
            compare_bit("rlast", rlast, exp_last.pop_front());
         end
      end
      if (cont_rd_ack)
      begin
         ack_cnt++;
         started++;
      end
      if (rd_done)
      begin
         done_cnt++;
         seq_open = 1'b0;
      end
      if (fresh_pending)
      begin
         fresh_pending = 1'b0;
         started = 1;
         // write request is a single cycle
         if (r.is_wr)
            seq_open = 1'b0;
      end
      cyc++;
   endtask

   task automatic run_test(input int idx);
      test_row_t r;
      int        err_start;
      int        i;
      r = rows[idx];
      err_start = errors;
      beat_cnt = 0;
      done_cnt = 0;
      ack_cnt = 0;
      started = 0;
      ptr = 0;
      cyc = 0;
      nwords = r.nchain * (r.len + 1);
      for (i = 0; i < nwords; i++)
         gen_word(words[i]);
      build_expected(r);
      fresh_pending = 1'b1;
      seq_open = 1'b1;
      // nothing ends a write, so a fixed window
      if (r.is_wr)
         repeat (WR_CYCLES) one_cycle(r);
      else
         while (done_cnt == 0)
            one_cycle(r);
      // catch stray beats and pulses
      repeat (TAIL_CYCLES) one_cycle(r);
      match_count("rd_done", done_cnt, r.exp_done);
      match_count("cont_rd_ack", ack_cnt, (r.exp_bursts > 0) ? r.exp_bursts - 1 : 0);
      match_count("beats", beat_cnt, r.exp_bursts * (r.len + 1));
      errors += DUT.u_mem_rd_chk.fail_cnt - asrt_seen;
      asrt_seen = DUT.u_mem_rd_chk.fail_cnt;
      if (errors == err_start)
         $display("test %0d %s: ok, %0d beats", idx, names[idx], beat_cnt);
      else
         $display("test %0d %s: %0d errors", idx, names[idx], errors - err_start);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin : main
      int t;
      mem_clk = 1'b0;
      reset_n = 1'b0;
      xfer_valid = 1'b0;
      xfer_wr_rd = 1'b0;
      cont_rd_req = 1'b0;
      xfer_error = 1'b0;
      xfer_len = '0;
      xmittr_ack = 1'b0;
      illegal_instrn_err = 1'b0;
      dqs_toggle = 1'b0;
      rx_data = '0;
      rx_valid = 1'b0;
      rdata_ack = 1'b0;
      rng = SEED;
      errors = 0;
      checks = 0;
      asrt_seen = 0;
      fresh_pending = 1'b0;
      seq_open = 1'b0;
      table_ready = 1'b0;
      load_table();
      table_ready = 1'b1;
      repeat (5) @(negedge mem_clk);
      reset_n = 1'b1;
      repeat (2) @(negedge mem_clk);
      // quiet outputs out of reset
      compare_bit("rx_ready", rx_ready, 1'b0);
      compare_bit("rdata_valid", rdata_valid, 1'b0);
      compare_bit("rd_done", rd_done, 1'b0);
      compare_bit("cont_rd_ack", cont_rd_ack, 1'b0);
      for (t = 0; t < n_rows; t++)
         run_test(t);
      $display("%0d tests, %0d checks, %0d errors", n_rows, checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // run limit from the table, beats plus timeout wait plus slack per row
   initial
   begin : watchdog
      int budget;
      int t;
      wait (table_ready);
      budget = 8;
      for (t = 0; t < n_rows; t++)
         budget += rows[t].nchain * (rows[t].len + 1) + `DQS_TIMEOUT_CYCLES + 20;
      #(budget * 2 * CLK_HALF);
      $display("watchdog expired after %0d cycles, a read never completed", budget);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/mem_rd_pkg.sv
verilog/rd_xfer_if.sv
verilog/read_sequencer.sv
verilog/dqs_watchdog.sv
verilog/rdata_ctrl.sv
verilog/mem_rd_top.sv
bench/mem_rd_chk.sv
bench/mem_rd_tb.sv
